/* source/idct_pkg.sv */
// idct_pkg: widths, image plane constants and bus structs shared by the IDCT block engine
package idct_pkg;

	localparam int BLOCK_DIM = 8;
	localparam int BLOCK_WORDS = BLOCK_DIM * BLOCK_DIM;
	localparam int IMAGE_WIDTH = 320;
	localparam int IMAGE_HEIGHT = 240;
	localparam int BLOCK_COLS = IMAGE_WIDTH / BLOCK_DIM; // 40
	localparam int BLOCK_ROWS = IMAGE_HEIGHT / BLOCK_DIM; // 30
	localparam int S_PRIME_BASE = 76800; // coefficients sit after the Y plane
	localparam int Y_WRITE_BASE = 0;
	localparam int SRAM_READ_LATENCY = 2;
	localparam int PASS1_SHIFT = 8;
	localparam int PASS2_SHIFT = 16;
	localparam int COEF_SCALE = 4096;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;
	typedef logic [5:0] ram_addr_t;
	typedef logic signed [31:0] coef_t;
	typedef logic [7:0] pixel_t;

	typedef struct packed {
		logic [4:0] row;
		logic [5:0] col;
	} block_pos_t;

	typedef struct packed {
		sram_addr_t address;
		sram_data_t write_data;
		logic we_n;
	} sram_req_t;

	typedef struct packed {
		ram_addr_t addr;
		coef_t data;
		logic wren;
	} ram_wr_t;

	typedef struct packed {
		ram_addr_t addr_a;
		ram_addr_t addr_b;
	} ram_rd_t;

	typedef struct packed {
		coef_t q_a;
		coef_t q_b;
	} ram_q_t;

endpackage

/* source/block_ram.sv */
// block_ram: 64x32 block RAM, one write port and two registered read ports
`timescale 1ns/1ps

module block_ram (
	input  logic CLOCK_50_I,
	input  idct_pkg::ram_wr_t wr,
	input  idct_pkg::ram_rd_t rd,
	output idct_pkg::ram_q_t q
);
	import idct_pkg::*;

	coef_t mem [BLOCK_WORDS];

	always_ff @(posedge CLOCK_50_I) begin
		if (wr.wren) begin
			mem[wr.addr] <= wr.data;
		end
		q.q_a <= mem[rd.addr_a]; // old data on a same-address write
		q.q_b <= mem[rd.addr_b];
	end

endmodule

/* source/dct_coeff_rom.sv */
// dct_coeff_rom: constant 8x8 DCT basis matrix C with two registered read ports
`timescale 1ns/1ps

module dct_coeff_rom (
	input  logic CLOCK_50_I,
	input  idct_pkg::ram_rd_t rd,
	output idct_pkg::ram_q_t q
);
	import idct_pkg::*;

	// C[r][c] = COEF_SCALE * a(c) * cos((2r+1) c pi/16), entry r*8 + c
	function automatic coef_t coef_entry(input ram_addr_t idx);
		logic [6:0] ang;
		logic [3:0] fold;
		logic neg;
		coef_t mag;
		ang = 7'({idx[5:3], 1'b1}) * 7'(idx[2:0]); // in steps of pi/16
		neg = ang[4] ^ ang[3]; // second and third quadrant
		fold = ang[3] ? (4'd0 - ang[3:0]) : ang[3:0];
		case (fold)
			4'd0: mag = 32'sd1448; // only the DC column, sqrt(1/8) scaling
			4'd1: mag = 32'sd2009;
			4'd2: mag = 32'sd1892;
			4'd3: mag = 32'sd1703;
			4'd4: mag = 32'sd1448;
			4'd5: mag = 32'sd1138;
			4'd6: mag = 32'sd784;
			4'd7: mag = 32'sd400;
			default: mag = '0;
		endcase
		return neg ? -mag : mag;
	endfunction

	always_ff @(posedge CLOCK_50_I) begin
		q <= '{q_a: coef_entry(rd.addr_a), q_b: coef_entry(rd.addr_b)};
	end

endmodule

/* source/block_fetch.sv */
// block_fetch: reads the 64 coefficients of a block from SRAM into the S' block RAM
`timescale 1ns/1ps

module block_fetch (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  logic fetch_go,
	input  idct_pkg::block_pos_t pos,
	input  idct_pkg::sram_data_t sram_read_data,
	output idct_pkg::sram_req_t fetch_req,
	output idct_pkg::ram_wr_t s_wr,
	output logic fetch_done
);
	import idct_pkg::*;

	logic active;
	ram_addr_t cnt; // element r*8 + c
	logic [SRAM_READ_LATENCY-1:0] vld_dly;
	ram_addr_t addr_dly [SRAM_READ_LATENCY];
	logic wr_en;
	ram_addr_t wr_addr;
	coef_t wr_data;

	assign fetch_req.address = sram_addr_t'(S_PRIME_BASE
		+ int'(pos.row) * BLOCK_DIM * IMAGE_WIDTH + int'(pos.col) * BLOCK_DIM
		+ int'(cnt[5:3]) * IMAGE_WIDTH + int'(cnt[2:0]));
	assign fetch_req.write_data = '0;
	assign fetch_req.we_n = 1'b1; // reads only
	assign s_wr = '{addr: wr_addr, data: wr_data, wren: wr_en};

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			active <= 1'b0;
			cnt <= '0;
			vld_dly <= '0;
			wr_en <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			if (fetch_go) begin
				active <= 1'b1;
				cnt <= '0;
			end else if (active) begin
				cnt <= cnt + 6'd1;
				if (cnt == 6'd63) begin
					active <= 1'b0;
				end
			end
			vld_dly <= {vld_dly[SRAM_READ_LATENCY-2:0], active};
			wr_en <= vld_dly[SRAM_READ_LATENCY-1];
			fetch_done <= vld_dly[SRAM_READ_LATENCY-1] && addr_dly[SRAM_READ_LATENCY-1] == 6'd63;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		addr_dly[0] <= cnt;
		for (int n = 1; n < SRAM_READ_LATENCY; n++) begin
			addr_dly[n] <= addr_dly[n-1];
		end
		wr_addr <= addr_dly[SRAM_READ_LATENCY-1]; // lines up with returning data
		wr_data <= {{16{sram_read_data[15]}}, sram_read_data};
	end

endmodule

/* source/matrix_engine.sv */
// matrix_engine: T = S'C then S = C'T with shifts and clipping, two products per cycle
`timescale 1ns/1ps

module matrix_engine (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  logic compute_go,
	output idct_pkg::ram_rd_t s_rd,
	input  idct_pkg::ram_q_t s_q,
	output idct_pkg::ram_rd_t t_rd,
	input  idct_pkg::ram_q_t t_q,
	output idct_pkg::ram_wr_t t_wr,
	output idct_pkg::ram_rd_t rom_rd,
	input  idct_pkg::ram_q_t rom_q,
	output idct_pkg::pixel_t pix,
	output logic pix_valid,
	output logic compute_done
);
	import idct_pkg::*;

	typedef struct packed {
		logic valid;
		logic pass;
		logic first;
		logic last;
		ram_addr_t elem;
	} tag_t;

	logic run;
	logic [8:0] cnt; // pass, i, j, k pair
	logic [2:0] row_i;
	logic [2:0] col_j;
	logic [2:0] rom_sel;
	logic [1:0] kp;
	tag_t tag_0;
	tag_t tag_1;
	tag_t tag_2;
	ram_q_t op_q;
	logic signed [63:0] prod_a;
	logic signed [63:0] prod_b;
	logic signed [63:0] acc;
	logic signed [63:0] sum;
	logic signed [63:0] scaled;
	logic t_wren;
	ram_addr_t t_addr;
	coef_t t_data;

	assign row_i = cnt[7:5];
	assign col_j = cnt[4:2];
	assign kp = cnt[1:0];
	assign rom_sel = cnt[8] ? row_i : col_j; // C[k][j] then C[k][i]
	assign tag_0 = '{valid: run, pass: cnt[8], first: kp == 2'd0, last: kp == 2'd3,
		elem: cnt[7:2]};

	assign s_rd = '{addr_a: {row_i, kp, 1'b0}, addr_b: {row_i, kp, 1'b1}};
	assign t_rd = '{addr_a: {kp, 1'b0, col_j}, addr_b: {kp, 1'b1, col_j}};
	assign rom_rd = '{addr_a: {kp, 1'b0, rom_sel}, addr_b: {kp, 1'b1, rom_sel}};
	assign t_wr = '{addr: t_addr, data: t_data, wren: t_wren};

	assign op_q = tag_1.pass ? t_q : s_q;
	assign sum = (tag_2.first ? 64'sd0 : acc) + prod_a + prod_b;
	assign scaled = tag_2.pass ? (sum >>> PASS2_SHIFT) : (sum >>> PASS1_SHIFT);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			run <= 1'b0;
			cnt <= '0;
			tag_1 <= '0;
			tag_2 <= '0;
			t_wren <= 1'b0;
			pix_valid <= 1'b0;
			compute_done <= 1'b0;
		end else begin
			if (compute_go) begin
				run <= 1'b1;
				cnt <= '0;
			end else if (run) begin
				cnt <= cnt + 9'd1;
				if (cnt == 9'd511) begin
					run <= 1'b0;
				end
			end
			tag_1 <= tag_0;
			tag_2 <= tag_1;
			t_wren <= tag_2.valid && tag_2.last && !tag_2.pass;
			pix_valid <= tag_2.valid && tag_2.last && tag_2.pass;
			compute_done <= tag_2.valid && tag_2.last && tag_2.pass && tag_2.elem == 6'd63;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		prod_a <= 64'($signed(op_q.q_a)) * 64'($signed(rom_q.q_a));
		prod_b <= 64'($signed(op_q.q_b)) * 64'($signed(rom_q.q_b));
		acc <= sum;
		t_addr <= tag_2.elem;
		t_data <= scaled[31:0];
		if (scaled < 64'sd0) begin
			pix <= '0;
		end else if (scaled > 64'sd255) begin
			pix <= 8'd255;
		end else begin
			pix <= scaled[7:0];
		end
	end

endmodule

/* source/pixel_writer.sv */
// pixel_writer: pairs row-major pixels into 16-bit words and writes them to the Y plane
`timescale 1ns/1ps

module pixel_writer (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  idct_pkg::block_pos_t pos,
	input  idct_pkg::pixel_t pix,
	input  logic pix_valid,
	output idct_pkg::sram_req_t write_req,
	output logic block_written
);
	import idct_pkg::*;

	logic odd; // next strobe carries the odd pixel
	logic [4:0] word_cnt;
	pixel_t even_pix;
	logic we_n;
	sram_addr_t wr_addr;
	sram_data_t wr_data;

	assign write_req = '{address: wr_addr, write_data: wr_data, we_n: we_n};

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			odd <= 1'b0;
			word_cnt <= '0;
			we_n <= 1'b1;
			block_written <= 1'b0;
		end else begin
			we_n <= !(pix_valid && odd);
			block_written <= pix_valid && odd && word_cnt == 5'd31;
			if (pix_valid) begin
				odd <= !odd;
				if (odd) begin
					word_cnt <= word_cnt + 5'd1; // wraps for the next block
				end
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (pix_valid && !odd) begin
			even_pix <= pix;
		end
		if (pix_valid && odd) begin
			wr_data <= {even_pix, pix};
			wr_addr <= sram_addr_t'(Y_WRITE_BASE
				+ int'(pos.row) * BLOCK_DIM * IMAGE_WIDTH / 2 + int'(pos.col) * BLOCK_DIM / 2
				+ int'(word_cnt[4:2]) * IMAGE_WIDTH / 2 + int'(word_cnt[1:0]));
		end
	end

endmodule

/* source/idct_ctrl.sv */
// idct_ctrl: block sequencer, latches the block position and owns the SRAM port select
`timescale 1ns/1ps

module idct_ctrl (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  logic start,
	input  idct_pkg::block_pos_t block_pos,
	input  logic fetch_done,
	input  logic compute_done,
	input  logic block_written,
	input  idct_pkg::sram_req_t fetch_req,
	input  idct_pkg::sram_req_t write_req,
	output idct_pkg::block_pos_t pos,
	output logic fetch_go,
	output logic compute_go,
	output idct_pkg::sram_req_t sram_req,
	output logic done
);

	typedef enum logic [1:0] {S_IDLE, S_FETCH, S_COMPUTE, S_DRAIN} state_t;

	state_t state;

	assign sram_req = (state == S_FETCH) ? fetch_req : write_req; // writer owns the port otherwise

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state <= S_IDLE;
			pos <= '0;
			fetch_go <= 1'b0;
			compute_go <= 1'b0;
			done <= 1'b0;
		end else begin
			fetch_go <= 1'b0;
			compute_go <= 1'b0;
			done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin // start is only seen here
						pos <= block_pos;
						fetch_go <= 1'b1;
						state <= S_FETCH;
					end
				end
				S_FETCH: begin
					if (fetch_done) begin
						compute_go <= 1'b1;
						state <= S_COMPUTE;
					end
				end
				S_COMPUTE: begin
					if (compute_done) begin
						state <= S_DRAIN;
					end
				end
				S_DRAIN: begin
					if (block_written) begin // last word is on the bus
						done <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* source/idct_top.sv */
// idct_top: 8x8 inverse DCT block engine, SRAM coefficients in, packed Y pixels out
`timescale 1ns/1ps

module idct_top (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  logic start,
	input  idct_pkg::block_pos_t block_pos,
	input  idct_pkg::sram_data_t sram_read_data,
	output idct_pkg::sram_req_t sram_req,
	output logic done
);
	import idct_pkg::*;

	block_pos_t pos;
	logic fetch_go;
	logic fetch_done;
	logic compute_go;
	logic compute_done;
	logic block_written;
	sram_req_t fetch_req;
	sram_req_t write_req;
	ram_wr_t s_wr;
	ram_wr_t t_wr;
	ram_rd_t s_rd;
	ram_rd_t t_rd;
	ram_rd_t rom_rd;
	ram_q_t s_q;
	ram_q_t t_q;
	ram_q_t rom_q;
	pixel_t pix;
	logic pix_valid;

	idct_ctrl ctrl_i (.*);

	block_fetch fetch_i (.*);

	block_ram s_prime_ram (
		.CLOCK_50_I(CLOCK_50_I),
		.wr(s_wr),
		.rd(s_rd),
		.q(s_q)
	);

	block_ram t_ram (
		.CLOCK_50_I(CLOCK_50_I),
		.wr(t_wr),
		.rd(t_rd),
		.q(t_q)
	);

	dct_coeff_rom coeff_rom (
		.CLOCK_50_I(CLOCK_50_I),
		.rd(rom_rd),
		.q(rom_q)
	);

	matrix_engine engine_i (.*);

	pixel_writer writer_i (.*);

endmodule

/* sim/sram_model.sv */
// sram_model: behavioral 256K x 16 SRAM, writes on we_n low, reads with a fixed latency
`timescale 1ns/1ps

module sram_model (
	input  logic CLOCK_50_I,
	input  idct_pkg::sram_req_t req,
	output idct_pkg::sram_data_t read_data
);
	import idct_pkg::*;

	sram_data_t mem [2**18];
	sram_addr_t addr_pipe [SRAM_READ_LATENCY-1];

	initial begin
		for (int a = 0; a < 2**18; a++) begin
			mem[a] = 16'(a) ^ 16'(a >> 2); // every address bit shows up in the fill
		end
	end

	always @(posedge CLOCK_50_I) begin
		if (!req.we_n) begin
			mem[req.address] <= req.write_data;
		end
		addr_pipe[0] <= req.address;
		for (int n = 1; n < SRAM_READ_LATENCY - 1; n++) begin
			addr_pipe[n] <= addr_pipe[n-1];
		end
		read_data <= mem[addr_pipe[SRAM_READ_LATENCY-2]]; // last stage of the read pipe
	end

endmodule

/* sim/tb_idct.sv */
// tb_idct: runs blocks through the IDCT engine and checks every Y plane write against a model
`timescale 1ns/1ps

module tb_idct;
	import idct_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int BLOCK_CYCLES = 1000; // one block takes well under this
	localparam int NUM_BLOCKS = 6;
	localparam int MAX_CYCLES = NUM_BLOCKS * BLOCK_CYCLES + 2000;

	logic CLOCK_50_I;
	logic resetn;
	logic start;
	block_pos_t block_pos;
	sram_data_t sram_read_data;
	sram_req_t sram_req;
	logic done;

	int seed;
	int cycles = 0;
	int value_errors = 0;
	int other_errors = 0;
	int block_writes = 0;
	int write_total = 0;
	int done_total = 0;
	bit started = 1'b0;
	int c_rom [BLOCK_WORDS];
	int s_in [BLOCK_WORDS];
	int pix_exp [BLOCK_WORDS];
	sram_data_t exp_y [2**18];
	bit exp_set [2**18];

	idct_top dut_i (.*);

	sram_model sram_i (.CLOCK_50_I(CLOCK_50_I), .req(sram_req), .read_data(sram_read_data));

	initial begin
		CLOCK_50_I = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50_I = ~CLOCK_50_I;
	end

	always @(posedge CLOCK_50_I) begin
		cycles <= cycles + 1;
		if (resetn && done) begin
			block_writes <= 0;
			done_total <= done_total + 1;
		end else if (resetn && !sram_req.we_n) begin
			block_writes <= block_writes + 1;
			write_total <= write_total + 1;
		end
	end

	always @(posedge CLOCK_50_I) begin
		if (cycles == MAX_CYCLES) begin
			$display("run stopped by timeout after %0d cycles, value errors: %0d, other errors: %0d",
				cycles, value_errors, other_errors);
			$display("test failed");
			$finish;
		end
	end

	assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!started |-> !done && sram_req.we_n)
	else begin
		other_errors++;
		$display("done or an SRAM write appeared at %0t before any start", $time);
	end

	assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!sram_req.we_n |-> exp_set[sram_req.address])
	else begin
		other_errors++;
		$display("write at %0t to address %0d lies outside the current block", $time,
			$sampled(sram_req.address));
	end

	assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!sram_req.we_n && exp_set[sram_req.address] |->
		sram_req.write_data == exp_y[sram_req.address])
	else begin
		value_errors++;
		$display("error at %0t: sram_req.write_data expected %h got %h", $time,
			exp_y[$sampled(sram_req.address)], $sampled(sram_req.write_data));
	end

	assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		done |-> !$past(sram_req.we_n))
	else begin
		other_errors++;
		$display("done at %0t did not follow the last write by one cycle", $time);
	end

	assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		done |-> block_writes == 32)
	else begin
		value_errors++;
		$display("error at %0t: block write count expected 32 got %0d", $time,
			$sampled(block_writes));
	end

	assert property (@(posedge CLOCK_50_I) disable iff (!resetn) done |=> !done)
	else begin
		other_errors++;
		$display("done stayed high for more than one cycle at %0t", $time);
	end

	task automatic build_rom();
		real a;
		real v;
		for (int r = 0; r < BLOCK_DIM; r++) begin
			for (int c = 0; c < BLOCK_DIM; c++) begin
				a = (c == 0) ? $sqrt(1.0 / 8.0) : 0.5;
				v = COEF_SCALE * a * $cos((2 * r + 1) * c * 3.14159265358979 / 16.0);
				c_rom[r * BLOCK_DIM + c] = (v < 0.0) ? -$rtoi(0.5 - v) : $rtoi(v + 0.5);
			end
		end
	endtask

	// T = S'C >>> 8, then S = C'T >>> 16 clipped to a pixel
	task automatic run_model();
		longint acc;
		int t_mid [BLOCK_WORDS];
		for (int e = 0; e < BLOCK_WORDS; e++) begin
			acc = 0;
			for (int k = 0; k < BLOCK_DIM; k++) begin
				acc += longint'(s_in[(e / 8) * 8 + k]) * c_rom[k * 8 + e % 8];
			end
			t_mid[e] = int'(acc >>> PASS1_SHIFT);
		end
		for (int e = 0; e < BLOCK_WORDS; e++) begin
			acc = 0;
			for (int k = 0; k < BLOCK_DIM; k++) begin
				acc += longint'(c_rom[k * 8 + e / 8]) * t_mid[k * 8 + e % 8];
			end
			acc = acc >>> PASS2_SHIFT;
			pix_exp[e] = (acc < 0) ? 0 : (acc > 255) ? 255 : int'(acc);
		end
	endtask

	function automatic int y_word_addr(input block_pos_t pos, input int w);
		return Y_WRITE_BASE + int'(pos.row) * 1280 + int'(pos.col) * 4 + (w / 4) * 160 + w % 4;
	endfunction

	task automatic load_block(input block_pos_t pos, input int kind);
		int base;
		base = S_PRIME_BASE + int'(pos.row) * 2560 + int'(pos.col) * BLOCK_DIM;
		for (int e = 0; e < BLOCK_WORDS; e++) begin
			case (kind)
				0: s_in[e] = (e == 0) ? 512 : 0; // DC only
				1: s_in[e] = $random(seed) % 2049;
				default: s_in[e] = int'($signed(16'($random(seed))));
			endcase
			sram_i.mem[base + (e / 8) * IMAGE_WIDTH + e % 8] = 16'(s_in[e]);
		end
		run_model();
		for (int w = 0; w < 32; w++) begin
			exp_y[y_word_addr(pos, w)] = {8'(pix_exp[2 * w]), 8'(pix_exp[2 * w + 1])};
			exp_set[y_word_addr(pos, w)] = 1'b1;
		end
	endtask

	task automatic check_stored(input block_pos_t pos);
		int addr;
		for (int w = 0; w < 32; w++) begin
			addr = y_word_addr(pos, w);
			assert (sram_i.mem[addr] == exp_y[addr])
			else begin
				value_errors++;
				$display("error at %0t: sram_i.mem[%0d] expected %h got %h", $time, addr,
					exp_y[addr], sram_i.mem[addr]);
			end
		end
	endtask

	// called and returns 2 ns after a rising edge
	task automatic run_block(input block_pos_t pos, input int kind, input bit busy_start);
		block_pos_t other;
		other = '{row: 5'd1, col: 6'd1};
		load_block(pos, kind);
		started = 1'b1;
		start = 1'b1;
		block_pos = pos;
		@(posedge CLOCK_50_I);
		#DRIVE_DELAY;
		start = 1'b0;
		if (busy_start) begin
			repeat (100) @(posedge CLOCK_50_I); // lands inside the compute phase
			#DRIVE_DELAY;
			start = 1'b1;
			block_pos = other;
			@(posedge CLOCK_50_I);
			#DRIVE_DELAY;
			start = 1'b0;
		end
		do begin
			@(posedge CLOCK_50_I);
			#DRIVE_DELAY;
		end while (!done);
		for (int w = 0; w < 32; w++) begin
			exp_set[y_word_addr(pos, w)] = 1'b0; // later writes here are stray
		end
		check_stored(pos);
	endtask

	initial begin
		seed = 68;
		resetn = 1'b0;
		start = 1'b0;
		block_pos = '0;
		build_rom();
		repeat (5) @(posedge CLOCK_50_I);
		#DRIVE_DELAY;
		resetn = 1'b1;
		repeat (4) @(posedge CLOCK_50_I);
		#DRIVE_DELAY;
		run_block('{row: 5'd3, col: 6'd5}, 0, 1'b0);
		run_block('{row: 5'd12, col: 6'd20}, 1, 1'b0);
		run_block('{row: 5'd7, col: 6'd33}, 2, 1'b0);
		run_block('{row: 5'd0, col: 6'd0}, 1, 1'b0);
		run_block('{row: 5'd29, col: 6'd39}, 1, 1'b0);
		check_stored('{row: 5'd0, col: 6'd0});
		run_block('{row: 5'd15, col: 6'd10}, 1, 1'b1);
		repeat (BLOCK_CYCLES) @(posedge CLOCK_50_I); // room for a stray block to show up
		assert (done_total == NUM_BLOCKS)
		else begin
			other_errors++;
			$display("saw %0d done pulses for %0d blocks", done_total, NUM_BLOCKS);
		end
		assert (write_total == NUM_BLOCKS * 32)
		else begin
			other_errors++;
			$display("saw %0d SRAM writes for %0d blocks", write_total, NUM_BLOCKS);
		end
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* idct.f */
source/idct_pkg.sv
source/block_ram.sv
source/dct_coeff_rom.sv
source/block_fetch.sv
source/matrix_engine.sv
source/pixel_writer.sv
source/idct_ctrl.sv
source/idct_top.sv
sim/sram_model.sv
sim/tb_idct.sv

/* run_sim.sh */
#!/bin/sh
# Build the IDCT testbench with Verilator, run it and look for the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f idct.f --top-module tb_idct -Mdir obj_dir -o tb_idct

out=$(./obj_dir/tb_idct)
echo "$out"

echo "$out" | grep -qx "test passed"
